// File: hdl/twiddle_quarter.svh
`ifndef TWIDDLE_QUARTER_SVH
`define TWIDDLE_QUARTER_SVH

// Entry k is round(256 * cos(2*pi*k/256)) for k = 0 to 64
// The first quadrant of the circle is enough to rebuild every factor of the frame
localparam twiddle_t COS_QUARTER [0:QUARTER] = '{
	256,
	256,
	256,
	255,
	255,
	254,
	253,
	252,
	251,
	250,
	248,
	247,
	245,
	243,
	241,
	239,
	237, // k = 16 is one sixteenth of a turn
	234,
	231,
	229,
	226,
	223,
	220,
	216,
	213,
	209,
	206,
	202,
	198,
	194,
	190,
	185,
	181, // Eighth of a turn, 256 / sqrt(2)
	177,
	172,
	167,
	162,
	157,
	152,
	147,
	142,
	137,
	132,
	126,
	121,
	115,
	109,
	104,
	98,
	92,
	86,
	80,
	74,
	68,
	62,
	56,
	50,
	44,
	38,
	31,
	25,
	19,
	13,
	6,
	0 // Quarter turn
};

`endif

// File: hdl/fft_pkg.sv
package fft_pkg;

	// One pipeline stage handles a frame of N_POINTS samples per phase
	localparam int N_POINTS = 128;
	localparam int IDX_W    = $clog2(N_POINTS);

	// The quarter turn of the twiddle circle sits halfway through the frame
	localparam int QUARTER = N_POINTS / 2;

	// Fixed point format of one twiddle part
	localparam int TW_W    = 24;
	localparam int TW_FRAC = 8; // A value of one is 256

	typedef logic [IDX_W-1:0] idx_t;
	typedef logic signed [TW_W-1:0] twiddle_t;

	// Unity factor, held on the outputs whenever no twiddle is valid
	localparam twiddle_t TW_ONE = twiddle_t'(1 << TW_FRAC);

	// Phases of one frame, stepped in this order and back to idle
	typedef enum logic [1:0] {
		PH_IDLE = 2'd0,
		PH_FILL = 2'd1,
		PH_BFLY = 2'd2,
		PH_TWID = 2'd3
	} phase_t;

endpackage

// File: hdl/sample_counter.sv
`timescale 1ns/1ns

module sample_counter import fft_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic en_i,
	output idx_t index_o,
	output logic last_o
);

	idx_t index_q;

	// Final sample of the phase, used by the controller to step on
	assign last_o  = (index_q == idx_t'(N_POINTS - 1));
	assign index_o = index_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			index_q <= '0;
		end else if (!en_i) begin
			index_q <= '0; // Held at zero so the next frame starts at its first sample
		end else if (last_o) begin
			index_q <= '0;
		end else begin
			index_q <= index_q + 1'b1;
		end
	end

endmodule

// File: hdl/phase_ctrl.sv
`timescale 1ns/1ns

module phase_ctrl import fft_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   in_valid_i,
	input  logic   last_i,
	output logic   count_en_o,
	output logic   twid_en_o,
	output phase_t phase_o
);

	phase_t phase_q;
	phase_t phase_next;
	logic   count_en;
	logic   phase_done;

	// The counter runs through every phase except idle
	assign count_en   = (phase_q != PH_IDLE);
	assign phase_done = count_en && last_i;

	always_comb begin
		phase_next = phase_q;
		unique case (phase_q)
			PH_IDLE: begin
				if (in_valid_i) phase_next = PH_FILL; // A strobe in any other phase is dropped
			end
			PH_FILL: begin
				if (phase_done) phase_next = PH_BFLY;
			end
			PH_BFLY: begin
				if (phase_done) phase_next = PH_TWID;
			end
			PH_TWID: begin
				if (phase_done) phase_next = PH_IDLE;
			end
			default: phase_next = PH_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q <= PH_IDLE;
		end else begin
			phase_q <= phase_next;
		end
	end

	assign count_en_o = count_en;
	assign twid_en_o  = (phase_q == PH_TWID);
	assign phase_o    = phase_q;

endmodule

// File: hdl/twiddle_rom.sv
`timescale 1ns/1ns

module twiddle_rom import fft_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     en_i,
	input  idx_t     index_i,
	output twiddle_t w_r_o,
	output twiddle_t w_i_o,
	output logic     w_valid_o
);

`include "twiddle_quarter.svh"

	// Position inside the current quadrant and its mirror about the quarter turn
	logic     upper_half;
	idx_t     fold_idx;
	idx_t     mirror_idx;

	// Table reads, one straight and one mirrored
	twiddle_t cos_direct;
	twiddle_t cos_mirror;

	// Rebuilt factor ahead of the output register
	twiddle_t w_r_next;
	twiddle_t w_i_next;

	assign upper_half = index_i[IDX_W-1];
	assign fold_idx   = {1'b0, index_i[IDX_W-2:0]}; // Equals m once the index passes 64
	assign mirror_idx = idx_t'(QUARTER) - fold_idx;

	assign cos_direct = COS_QUARTER[fold_idx];
	assign cos_mirror = COS_QUARTER[mirror_idx];

	// In the first quadrant sin(x) is cos(pi/2 - x)
	// In the second quadrant the cosine turns negative and sin(x) equals cos(x - pi/2)
	always_comb begin
		if (!upper_half) begin
			w_r_next = cos_direct;
			w_i_next = -cos_mirror;
		end else begin
			w_r_next = -cos_mirror;
			w_i_next = -cos_direct;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			w_r_o     <= TW_ONE;
			w_i_o     <= '0;
			w_valid_o <= 1'b0;
		end else if (en_i) begin
			w_r_o     <= w_r_next;
			w_i_o     <= w_i_next;
			w_valid_o <= 1'b1;
		end else begin
			w_r_o     <= TW_ONE; // Outside the twiddle phase the stage multiplies by one
			w_i_o     <= '0;
			w_valid_o <= 1'b0;
		end
	end

endmodule

// File: hdl/twiddle_seq_top.sv
`timescale 1ns/1ns

module twiddle_seq_top import fft_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid_i,
	output phase_t   phase_o,
	output twiddle_t w_r_o,
	output twiddle_t w_i_o,
	output logic     w_valid_o
);

	logic count_en;
	logic twid_en;
	idx_t index;
	logic last;

	// Frame controller, paced by the sample counter
	phase_ctrl phase_ctrl_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid_i (in_valid_i),
		.last_i     (last),
		.count_en_o (count_en),
		.twid_en_o  (twid_en),
		.phase_o    (phase_o)
	);

	sample_counter sample_counter_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.en_i    (count_en),
		.index_o (index),
		.last_o  (last)
	);

	// The factor for index k leaves the ROM one cycle after k is counted
	twiddle_rom twiddle_rom_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.en_i      (twid_en),
		.index_i   (index),
		.w_r_o     (w_r_o),
		.w_i_o     (w_i_o),
		.w_valid_o (w_valid_o)
	);

endmodule

// File: tests/clk_gen.sv
`timescale 1ns/1ns

module clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o; // 20 ns period
	end

	// Reset is released on a falling edge, away from the active clock edge
	initial begin
		rst_n_o = 1'b0;
		repeat (16) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

// File: tests/twiddle_checker.sv
`timescale 1ns/1ns

module twiddle_checker import fft_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input phase_t   phase_i,
	input twiddle_t w_r_i,
	input twiddle_t w_i_i,
	input logic     w_valid_i
);

	phase_t      prev_phase; // Phase seen one cycle earlier
	int unsigned run_len;    // Cycles in the run of prev_phase that ended last cycle

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prev_phase <= PH_IDLE;
			run_len    <= 1;
		end else begin
			prev_phase <= phase_i;
			run_len    <= (phase_i == prev_phase) ? run_len + 1 : 1;
		end
	end

	// The phase only steps forward, and the twiddle phase wraps back to idle
	assert property (@(posedge clk) disable iff (!rst_n)
		(phase_i != prev_phase) |-> (phase_i == phase_t'(prev_phase + 2'd1)))
	else $error("phase stepped from %s to %s", prev_phase.name(), phase_i.name());

	assert property (@(posedge clk) disable iff (!rst_n)
		w_valid_i |-> (prev_phase == PH_TWID))
	else $error("twiddle valid without a twiddle phase one cycle earlier");

	assert property (@(posedge clk) disable iff (!rst_n)
		!w_valid_i |-> (w_r_i == TW_ONE && w_i_i == '0))
	else $error("outputs are not unity while no twiddle is valid");

	// Each frame phase holds for exactly one frame of samples
	assert property (@(posedge clk) disable iff (!rst_n)
		(prev_phase != PH_IDLE && phase_i != prev_phase) |-> (run_len == N_POINTS))
	else $error("phase %s lasted %0d cycles", prev_phase.name(), run_len);

	assert property (@(posedge clk) disable iff (!rst_n)
		(prev_phase != PH_IDLE) |-> (run_len <= N_POINTS))
	else $error("phase %s runs past one frame", prev_phase.name());

endmodule

// File: tests/tb_top.sv
`timescale 1ns/1ns

module tb_top import fft_pkg::*; ;

	localparam int  SEED          = 54;
	localparam int  NUM_FRAMES    = 4;
	localparam int  MAX_GAP       = 24;  // Longest idle gap between frames in cycles
	localparam int  RESET_TIMEOUT = 100;
	localparam int  START_TIMEOUT = 200;
	localparam int  IDLE_TIMEOUT  = 8;
	localparam real PI            = 3.14159265358979;

	// A factor of one has the real part 256 and no imaginary part
	localparam twiddle_t UNITY_RE = 256;

	logic     clk;
	logic     rst_n;
	logic     in_valid_i;
	phase_t   phase_o;
	twiddle_t w_r_o;
	twiddle_t w_i_o;
	logic     w_valid_o;

	clk_gen clk_gen_inst (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	twiddle_seq_top twiddle_seq_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid_i (in_valid_i),
		.phase_o    (phase_o),
		.w_r_o      (w_r_o),
		.w_i_o      (w_i_o),
		.w_valid_o  (w_valid_o)
	);

	bind twiddle_seq_top twiddle_checker twiddle_checker_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.phase_i   (phase_o),
		.w_r_i     (w_r_o),
		.w_i_i     (w_i_o),
		.w_valid_i (w_valid_o)
	);

	function automatic int round_nearest(input real x);
		if (x >= 0.0) begin
			return $rtoi(x + 0.5);
		end else begin
			return -$rtoi(0.5 - x);
		end
	endfunction

	// W(k) = cos(2*pi*k/256) - j*sin(2*pi*k/256) with TW_FRAC fractional bits
	function automatic void reference_twiddle(input int k, output twiddle_t re,
		output twiddle_t im);
		real angle;
		real scale;
		angle = 2.0 * PI * real'(k) / real'(2 * N_POINTS);
		scale = real'(1 << TW_FRAC);
		re = twiddle_t'(round_nearest(scale * $cos(angle)));
		im = twiddle_t'(round_nearest(-scale * $sin(angle)));
	endfunction

	// Phase shown c cycles after the first fill cycle of a frame
	function automatic phase_t expected_phase(input int c);
		if (c < N_POINTS) begin
			return PH_FILL;
		end else if (c < 2 * N_POINTS) begin
			return PH_BFLY;
		end else if (c < 3 * N_POINTS) begin
			return PH_TWID;
		end else begin
			return PH_IDLE;
		end
	endfunction

	task automatic compare_twiddle(input string what, input twiddle_t actual,
		input twiddle_t expected);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1, "twiddle mismatch");
		end
	endtask

	task automatic compare_phase(input string what, input phase_t actual,
		input phase_t expected);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns: %s is %s, expected %s", $time, what, actual.name(),
				expected.name());
			$display("Simulation failed");
			$fatal(1, "phase mismatch");
		end
	endtask

	task automatic compare_bit(input string what, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1, "bit mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t ns while waiting for %s", $time, what);
		$display("Simulation failed");
		$fatal(1, "timeout");
	endtask

	task automatic check_idle_state();
		compare_phase("idle phase_o", phase_o, PH_IDLE);
		compare_bit("idle w_valid_o", w_valid_o, 1'b0);
		compare_twiddle("idle w_r_o", w_r_o, UNITY_RE);
		compare_twiddle("idle w_i_o", w_i_o, '0);
	endtask

	// The reference must reproduce the known corner factors before it judges the DUT
	task automatic check_reference_examples();
		twiddle_t re;
		twiddle_t im;
		reference_twiddle(0, re, im);
		compare_twiddle("reference real part of k = 0", re, 256);
		compare_twiddle("reference imaginary part of k = 0", im, 0);
		reference_twiddle(64, re, im);
		compare_twiddle("reference real part of k = 64", re, 0);
		compare_twiddle("reference imaginary part of k = 64", im, -256);
		reference_twiddle(127, re, im);
		compare_twiddle("reference real part of k = 127", re, -256);
		compare_twiddle("reference imaginary part of k = 127", im, -6);
	endtask

	initial begin : stimulus
		int gap;
		int frame;
		int i;
		int waited;
		in_valid_i = 1'b0;
		void'($urandom(SEED));
		waited = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clk);
			waited++;
			if (waited > RESET_TIMEOUT) report_timeout("reset release");
		end
		for (frame = 0; frame < NUM_FRAMES; frame++) begin
			gap = 1 + int'($urandom % MAX_GAP);
			repeat (gap) @(negedge clk);
			in_valid_i = 1'b1; // Start strobe
			for (i = 1; i <= 3 * N_POINTS; i++) begin
				@(negedge clk);
				in_valid_i = ($urandom % 48 == 0); // Stray strobes land inside the frame
			end
			@(negedge clk);
			in_valid_i = 1'b0;
			waited = 0;
			while (phase_o != PH_IDLE) begin
				@(negedge clk);
				waited++;
				if (waited > IDLE_TIMEOUT) report_timeout("the end of a frame");
			end
		end
	end

	initial begin : compare
		int       waited;
		int       frame;
		int       c;
		logic     strobe;
		bit       started;
		twiddle_t exp_r;
		twiddle_t exp_i;
		check_reference_examples();
		waited = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clk);
			waited++;
			if (waited > RESET_TIMEOUT) report_timeout("reset release");
		end
		@(negedge clk);
		check_idle_state();
		for (frame = 0; frame < NUM_FRAMES; frame++) begin
			started = 1'b0;
			waited  = 0;
			while (!started) begin
				@(posedge clk);
				strobe = in_valid_i;
				@(negedge clk);
				if (strobe) begin
					started = 1'b1;
				end else begin
					check_idle_state();
					waited++;
					if (waited > START_TIMEOUT) report_timeout("the start of a frame");
				end
			end
			// Cycle 0 is the first fill cycle and follows the strobe edge by one cycle
			for (c = 0; c <= 3 * N_POINTS; c++) begin
				if (c > 0) @(negedge clk);
				compare_phase($sformatf("phase_o at frame %0d cycle %0d", frame, c), phase_o,
					expected_phase(c));
				if (c > 2 * N_POINTS) begin
					reference_twiddle(c - 2 * N_POINTS - 1, exp_r, exp_i);
				end else begin
					exp_r = UNITY_RE;
					exp_i = '0;
				end
				compare_bit($sformatf("w_valid_o at frame %0d cycle %0d", frame, c), w_valid_o,
					c > 2 * N_POINTS);
				compare_twiddle($sformatf("w_r_o at frame %0d cycle %0d", frame, c), w_r_o, exp_r);
				compare_twiddle($sformatf("w_i_o at frame %0d cycle %0d", frame, c), w_i_o, exp_i);
			end
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// File: list.f
+incdir+hdl
hdl/fft_pkg.sv
hdl/sample_counter.sv
hdl/phase_ctrl.sv
hdl/twiddle_rom.sv
hdl/twiddle_seq_top.sv
tests/clk_gen.sv
tests/twiddle_checker.sv
tests/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f list.f --top-module tb_top \
	-Mdir obj_dir -o tb_top_sim \
	&& ./obj_dir/tb_top_sim 2>&1 | tee sim.log

grep -q "^Simulation completed successfully$" sim.log \
	&& echo "Run passed" \
	|| { echo "Run did not pass, see sim.log"; exit 1; }
